// ==== dispatch_macros.svh ====
// Width and register-count constants for the dispatch front end; include wherever sizes are needed
`ifndef DISPATCH_MACROS_SVH
`define DISPATCH_MACROS_SVH

// Lanes per fetch bundle
`define DISPATCH_WIDTH 2

// Lane count, holds 0 to DISPATCH_WIDTH
`define COUNT_BITS 2

// Data and address width
`define XLEN 32

// Architectural register file
`define ARCH_REG_COUNT 32
`define REG_IDX_BITS 5

// Physical register file, first ARCH_REG_COUNT tags busy at reset
`define PHYS_REG_COUNT 64
`define PHYS_TAG_BITS 6

// Hardwired zero register index
`define ZERO_REG 5'd0

// WFI encoding, treated as halt
`define HALT_WORD 32'h10500073

`endif

// ==== dispatch_pkg.sv ====
// Shared instruction-word view and decode enums; import into any dispatch module that needs them
`include "dispatch_macros.svh"

package dispatch_pkg;

    ////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////

    // Two overlays of one 32-bit word
    // r: R/I/U/J style with rd in bits 11:7
    // s: S/B style with the immediate split around rs1/rs2
    typedef union packed {
        struct packed {
            logic [6:0]                funct7;
            logic [`REG_IDX_BITS-1:0]  rs2;
            logic [`REG_IDX_BITS-1:0]  rs1;
            logic [2:0]                funct3;
            logic [`REG_IDX_BITS-1:0]  rd;
            logic [6:0]                opcode;
        } r;
        struct packed {
            logic [6:0]                imm_hi;
            logic [`REG_IDX_BITS-1:0]  rs2;
            logic [`REG_IDX_BITS-1:0]  rs1;
            logic [2:0]                funct3;
            logic [4:0]                imm_lo;
            logic [6:0]                opcode;
        } s;
    } inst_word_t;

    ////////////////////////////////////////
    // Decode results
    ////////////////////////////////////////

    // Functional unit class, zero value is plain ALU
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_MULT   = 3'd1,
        OP_BRANCH = 3'd2,
        OP_JUMP   = 3'd3,
        OP_LOAD   = 3'd4,
        OP_STORE  = 3'd5,
        OP_SYSTEM = 3'd6
    } op_class_e;

    // Source of operand B, zero value is rs2
    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_select_e;

    // RV32 base opcodes the decoder knows
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

endpackage

// ==== inst_decoder.sv ====
// Combinational single-lane RV32IM decoder; one instance per dispatch lane
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module inst_decoder (
    input  dispatch_pkg::inst_word_t  inst,
    output dispatch_pkg::op_class_e   op_class,
    output dispatch_pkg::opb_select_e opb_select,
    output logic [`XLEN-1:0]          imm,
    output logic                      uses_rd,
    output logic                      illegal,
    output logic                      halt
);
    import dispatch_pkg::*;

    opcode_e opcode;
    logic    writes_rd;

    assign opcode = opcode_e'(inst.r.opcode);

    ////////////////////////////////////////
    // Opcode classification
    ////////////////////////////////////////

    always_comb begin
        op_class   = OP_ALU;
        opb_select = OPB_IS_RS2;
        writes_rd  = 1'b0;
        illegal    = 1'b0;
        halt       = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                opb_select = OPB_IS_U_IMM;
                writes_rd  = 1'b1;
            end
            OPC_JAL: begin
                op_class   = OP_JUMP;
                opb_select = OPB_IS_J_IMM;
                writes_rd  = 1'b1;
            end
            OPC_JALR: begin
                op_class   = OP_JUMP;
                opb_select = OPB_IS_I_IMM;
                writes_rd  = 1'b1;
            end
            // Branches compare rs1/rs2, offset rides as operand B
            OPC_BRANCH: begin
                op_class   = OP_BRANCH;
                opb_select = OPB_IS_B_IMM;
            end
            OPC_LOAD: begin
                op_class   = OP_LOAD;
                opb_select = OPB_IS_I_IMM;
                writes_rd  = 1'b1;
            end
            OPC_STORE: begin
                op_class   = OP_STORE;
                opb_select = OPB_IS_S_IMM;
            end
            OPC_OP_IMM: begin
                opb_select = OPB_IS_I_IMM;
                writes_rd  = 1'b1;
            end
            // funct7 picks base ALU, alternate ALU or M-extension
            OPC_OP: begin
                writes_rd = 1'b1;
                if (inst.r.funct7 == 7'b0000001) begin
                    op_class = OP_MULT;
                end else if (inst.r.funct7 != 7'b0000000 && inst.r.funct7 != 7'b0100000) begin
                    illegal = 1'b1;
                end
            end
            OPC_SYSTEM: begin
                op_class = OP_SYSTEM;
                halt     = (inst == `HALT_WORD);
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // Illegal words and x0 targets never claim a physical register
    assign uses_rd = writes_rd && !illegal && (inst.r.rd != `ZERO_REG);

    ////////////////////////////////////////
    // Immediate extraction
    ////////////////////////////////////////

    always_comb begin
        case (opb_select)
            OPB_IS_I_IMM: imm = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2};
            // S and B read the split view
            OPB_IS_S_IMM: imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            OPB_IS_B_IMM: imm = {{19{inst.s.imm_hi[6]}}, inst.s.imm_hi[6], inst.s.imm_lo[0],
                                 inst.s.imm_hi[5:0], inst.s.imm_lo[4:1], 1'b0};
            OPB_IS_U_IMM: imm = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
            // J offset bits are scattered over funct7, rs2, rs1 and funct3
            OPB_IS_J_IMM: imm = {{11{inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rs1,
                                 inst.r.funct3, inst.r.rs2[0], inst.r.funct7[5:0],
                                 inst.r.rs2[4:1], 1'b0};
            default:      imm = '0;
        endcase
    end

endmodule

// ==== free_list.sv ====
// Physical register free bitmap; offers the lowest free tags to dispatch and takes releases
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module free_list (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic [`COUNT_BITS-1:0]      take,
    input  logic [`PHYS_REG_COUNT-1:0]  free_mask,
    output logic [`PHYS_TAG_BITS-1:0]   offer_tag [`DISPATCH_WIDTH],
    output logic [`DISPATCH_WIDTH-1:0]  offer_ok
);

    // One bit per physical register, set means free
    logic [`PHYS_REG_COUNT-1:0] free_bits;
    logic [`PHYS_REG_COUNT-1:0] taken_bits;

    // Priority encoder, returns {found, lowest set index}
    function automatic logic [`PHYS_TAG_BITS:0] lowest_free(
        input logic [`PHYS_REG_COUNT-1:0] bits
    );
        logic [`PHYS_TAG_BITS:0] result;
        result = '0;
        // Scan downward so the lowest set bit wins
        for (int i = `PHYS_REG_COUNT - 1; i >= 0; i--) begin
            if (bits[i]) begin
                result = {1'b1, `PHYS_TAG_BITS'(i)};
            end
        end
        return result;
    endfunction

    ////////////////////////////////////////
    // Offer selection
    ////////////////////////////////////////

    // Each encoder sees the bitmap minus the tags offered before it
    always_comb begin
        logic [`PHYS_REG_COUNT-1:0] remaining;
        logic [`PHYS_TAG_BITS:0]    enc;
        remaining = free_bits;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            enc          = lowest_free(remaining);
            offer_ok[i]  = enc[`PHYS_TAG_BITS];
            offer_tag[i] = enc[`PHYS_TAG_BITS-1:0];
            if (enc[`PHYS_TAG_BITS]) begin
                remaining[enc[`PHYS_TAG_BITS-1:0]] = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Bitmap update
    ////////////////////////////////////////

    // Offers are consumed lowest first, take says how many
    always_comb begin
        taken_bits = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if ((`COUNT_BITS'(i) < take) && offer_ok[i]) begin
                taken_bits[offer_tag[i]] = 1'b1;
            end
        end
    end

    // Release after take, so a tag taken and freed together stays free
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // Architectural mapping owns the low tags out of reset
            free_bits <= {{(`PHYS_REG_COUNT - `ARCH_REG_COUNT){1'b1}},
                          {`ARCH_REG_COUNT{1'b0}}};
        end else begin
            free_bits <= (free_bits & ~taken_bits) | free_mask;
        end
    end

endmodule

// ==== dispatch_packer.sv ====
// In-order lane selection and tag assignment; registers one dispatch packet per lane
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module dispatch_packer (
    input  logic                        clock,
    input  logic                        rst_n,
    // Fetch bundle
    input  logic                        bundle_valid,
    input  logic [`XLEN-1:0]            bundle_pc,
    input  dispatch_pkg::inst_word_t    bundle_insts [`DISPATCH_WIDTH],
    input  logic [`COUNT_BITS-1:0]      bundle_count,
    // Per-lane decode
    input  dispatch_pkg::op_class_e     dec_op_class [`DISPATCH_WIDTH],
    input  dispatch_pkg::opb_select_e   dec_opb_select [`DISPATCH_WIDTH],
    input  logic [`XLEN-1:0]            dec_imm [`DISPATCH_WIDTH],
    input  logic [`DISPATCH_WIDTH-1:0]  dec_uses_rd,
    input  logic [`DISPATCH_WIDTH-1:0]  dec_illegal,
    input  logic [`DISPATCH_WIDTH-1:0]  dec_halt,
    // Free list
    input  logic [`PHYS_TAG_BITS-1:0]   offer_tag [`DISPATCH_WIDTH],
    input  logic [`DISPATCH_WIDTH-1:0]  offer_ok,
    output logic [`COUNT_BITS-1:0]      take,
    // Back to fetch, same cycle
    output logic [`COUNT_BITS-1:0]      consumed,
    // Registered dispatch packet
    output logic                        dispatch_valid,
    output logic [`COUNT_BITS-1:0]      dispatch_count,
    output logic [`XLEN-1:0]            disp_pc [`DISPATCH_WIDTH],
    output dispatch_pkg::op_class_e     disp_op_class [`DISPATCH_WIDTH],
    output dispatch_pkg::opb_select_e   disp_opb_select [`DISPATCH_WIDTH],
    output logic [`XLEN-1:0]            disp_imm [`DISPATCH_WIDTH],
    output logic [`REG_IDX_BITS-1:0]    disp_rs1 [`DISPATCH_WIDTH],
    output logic [`REG_IDX_BITS-1:0]    disp_rs2 [`DISPATCH_WIDTH],
    output logic [`REG_IDX_BITS-1:0]    disp_rd [`DISPATCH_WIDTH],
    output logic [`DISPATCH_WIDTH-1:0]  disp_uses_rd,
    output logic [`PHYS_TAG_BITS-1:0]   disp_phys_rd [`DISPATCH_WIDTH],
    output logic [`DISPATCH_WIDTH-1:0]  disp_illegal,
    output logic [`DISPATCH_WIDTH-1:0]  disp_halt
);
    import dispatch_pkg::*;

    logic [`DISPATCH_WIDTH-1:0] lane_go;
    logic [`PHYS_TAG_BITS-1:0]  lane_tag [`DISPATCH_WIDTH];

    ////////////////////////////////////////
    // Lane selection
    ////////////////////////////////////////

    always_comb begin
        logic chain;
        int   used;
        int   n_go;
        chain = bundle_valid;
        used  = 0;
        n_go  = 0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            lane_go[i]  = 1'b0;
            lane_tag[i] = '0;
            // Lane needs a valid slot, a live chain and a tag if it writes rd
            if (chain && (`COUNT_BITS'(i) < bundle_count) &&
                (!dec_uses_rd[i] || offer_ok[used])) begin
                lane_go[i] = 1'b1;
                n_go       = n_go + 1;
                if (dec_uses_rd[i]) begin
                    lane_tag[i] = offer_tag[used];
                    used        = used + 1;
                end
                // Nothing dispatches behind a halt
                chain = !dec_halt[i];
            end else begin
                chain = 1'b0;
            end
        end
        take     = `COUNT_BITS'(used);
        consumed = `COUNT_BITS'(n_go);
    end

    ////////////////////////////////////////
    // Dispatch register
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dispatch_valid <= 1'b0;
            dispatch_count <= '0;
            disp_uses_rd   <= '0;
            disp_illegal   <= '0;
            disp_halt      <= '0;
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                disp_pc[i]         <= '0;
                disp_op_class[i]   <= OP_ALU;
                disp_opb_select[i] <= OPB_IS_RS2;
                disp_imm[i]        <= '0;
                disp_rs1[i]        <= '0;
                disp_rs2[i]        <= '0;
                disp_rd[i]         <= '0;
                disp_phys_rd[i]    <= '0;
            end
        end else begin
            dispatch_valid <= bundle_valid;
            dispatch_count <= consumed;
            disp_uses_rd   <= lane_go & dec_uses_rd;
            disp_illegal   <= lane_go & dec_illegal;
            disp_halt      <= lane_go & dec_halt;
            // Undispatched lanes read back as all zero
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                disp_pc[i]         <= lane_go[i] ? bundle_pc + `XLEN'(4 * i) : '0;
                disp_op_class[i]   <= lane_go[i] ? dec_op_class[i] : OP_ALU;
                disp_opb_select[i] <= lane_go[i] ? dec_opb_select[i] : OPB_IS_RS2;
                disp_imm[i]        <= lane_go[i] ? dec_imm[i] : '0;
                disp_rs1[i]        <= lane_go[i] ? bundle_insts[i].r.rs1 : '0;
                disp_rs2[i]        <= lane_go[i] ? bundle_insts[i].r.rs2 : '0;
                disp_rd[i]         <= lane_go[i] ? bundle_insts[i].r.rd : '0;
                disp_phys_rd[i]    <= lane_tag[i];
            end
        end
    end

endmodule

// ==== dispatch_front.sv ====
// Dispatch front end top level; connects lane decoders, free list and packer for the core
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module dispatch_front (
    input  logic                        clock,
    input  logic                        rst_n,
    // Fetch side
    input  logic                        bundle_valid,
    input  logic [`XLEN-1:0]            bundle_pc,
    input  dispatch_pkg::inst_word_t    bundle_insts [`DISPATCH_WIDTH],
    input  logic [`COUNT_BITS-1:0]      bundle_count,
    output logic [`COUNT_BITS-1:0]      consumed,
    // Retire side release
    input  logic [`PHYS_REG_COUNT-1:0]  free_mask,
    // Dispatch packet
    output logic                        dispatch_valid,
    output logic [`COUNT_BITS-1:0]      dispatch_count,
    output logic [`XLEN-1:0]            disp_pc [`DISPATCH_WIDTH],
    output dispatch_pkg::op_class_e     disp_op_class [`DISPATCH_WIDTH],
    output dispatch_pkg::opb_select_e   disp_opb_select [`DISPATCH_WIDTH],
    output logic [`XLEN-1:0]            disp_imm [`DISPATCH_WIDTH],
    output logic [`REG_IDX_BITS-1:0]    disp_rs1 [`DISPATCH_WIDTH],
    output logic [`REG_IDX_BITS-1:0]    disp_rs2 [`DISPATCH_WIDTH],
    output logic [`REG_IDX_BITS-1:0]    disp_rd [`DISPATCH_WIDTH],
    output logic [`DISPATCH_WIDTH-1:0]  disp_uses_rd,
    output logic [`PHYS_TAG_BITS-1:0]   disp_phys_rd [`DISPATCH_WIDTH],
    output logic [`DISPATCH_WIDTH-1:0]  disp_illegal,
    output logic [`DISPATCH_WIDTH-1:0]  disp_halt
);
    import dispatch_pkg::*;

    // Decoder to packer
    op_class_e                  dec_op_class [`DISPATCH_WIDTH];
    opb_select_e                dec_opb_select [`DISPATCH_WIDTH];
    logic [`XLEN-1:0]           dec_imm [`DISPATCH_WIDTH];
    logic [`DISPATCH_WIDTH-1:0] dec_uses_rd;
    logic [`DISPATCH_WIDTH-1:0] dec_illegal;
    logic [`DISPATCH_WIDTH-1:0] dec_halt;

    // Free list handshake
    logic [`PHYS_TAG_BITS-1:0]  offer_tag [`DISPATCH_WIDTH];
    logic [`DISPATCH_WIDTH-1:0] offer_ok;
    logic [`COUNT_BITS-1:0]     take;

    ////////////////////////////////////////
    // Lane decoders
    ////////////////////////////////////////

    for (genvar g = 0; g < `DISPATCH_WIDTH; g++) begin : g_dec
        inst_decoder dec_i (
            .inst      (bundle_insts[g]),
            .op_class  (dec_op_class[g]),
            .opb_select(dec_opb_select[g]),
            .imm       (dec_imm[g]),
            .uses_rd   (dec_uses_rd[g]),
            .illegal   (dec_illegal[g]),
            .halt      (dec_halt[g])
        );
    end

    ////////////////////////////////////////
    // Allocation and packing
    ////////////////////////////////////////

    free_list free_list0 (
        .clock    (clock),
        .rst_n    (rst_n),
        .take     (take),
        .free_mask(free_mask),
        .offer_tag(offer_tag),
        .offer_ok (offer_ok)
    );

    dispatch_packer packer0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .bundle_valid   (bundle_valid),
        .bundle_pc      (bundle_pc),
        .bundle_insts   (bundle_insts),
        .bundle_count   (bundle_count),
        .dec_op_class   (dec_op_class),
        .dec_opb_select (dec_opb_select),
        .dec_imm        (dec_imm),
        .dec_uses_rd    (dec_uses_rd),
        .dec_illegal    (dec_illegal),
        .dec_halt       (dec_halt),
        .offer_tag      (offer_tag),
        .offer_ok       (offer_ok),
        .take           (take),
        .consumed       (consumed),
        .dispatch_valid (dispatch_valid),
        .dispatch_count (dispatch_count),
        .disp_pc        (disp_pc),
        .disp_op_class  (disp_op_class),
        .disp_opb_select(disp_opb_select),
        .disp_imm       (disp_imm),
        .disp_rs1       (disp_rs1),
        .disp_rs2       (disp_rs2),
        .disp_rd        (disp_rd),
        .disp_uses_rd   (disp_uses_rd),
        .disp_phys_rd   (disp_phys_rd),
        .disp_illegal   (disp_illegal),
        .disp_halt      (disp_halt)
    );

endmodule

// ==== tb_dispatch_front.sv ====
// Self-checking testbench for the dispatch front end; applies a bundle table against a free-list model
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module tb_dispatch_front;
    import dispatch_pkg::*;

    localparam int CLOCK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_ENTRIES  = 12;
    localparam int NUM_RANDOM   = 12;
    // Random bundles run just ahead of this table row
    localparam int RANDOM_AT    = 8;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + (NUM_ENTRIES + NUM_RANDOM) * 4) * CLOCK_PERIOD;

    // Hand-encoded instruction words
    localparam logic [31:0] ADD_X3  = 32'h002081b3;  // add  x3, x1, x2
    localparam logic [31:0] MUL_X5  = 32'h027302b3;  // mul  x5, x6, x7
    localparam logic [31:0] ADDI_X4 = 32'hffb08213;  // addi x4, x1, -5
    localparam logic [31:0] LW_X8   = 32'hffc12403;  // lw   x8, -4(x2)
    localparam logic [31:0] SW_X5   = 32'hfe512a23;  // sw   x5, -12(x2)
    localparam logic [31:0] BEQ_M16 = 32'hfe2088e3;  // beq  x1, x2, -16
    localparam logic [31:0] LUI_X9  = 32'h123454b7;  // lui  x9, 0x12345
    localparam logic [31:0] JAL_X1  = 32'hff9ff0ef;  // jal  x1, -8
    localparam logic [31:0] RET     = 32'h00008067;  // jalr x0, 0(x1)
    localparam logic [31:0] BAD_OPC = 32'h0000057f;  // opcode 7f with rd x10
    localparam logic [31:0] WFI     = `HALT_WORD;

    // Expected decode of one lane
    typedef struct packed {
        op_class_e   op_class;
        opb_select_e opb_select;
        logic [31:0] imm;
        logic        uses_rd;
        logic        illegal;
        logic        halt;
    } lane_expect_t;

    logic                       clock = 1'b0;
    logic                       rst_n;
    logic                       bundle_valid;
    logic [`XLEN-1:0]           bundle_pc;
    inst_word_t                 bundle_insts [`DISPATCH_WIDTH];
    logic [`COUNT_BITS-1:0]     bundle_count;
    logic [`PHYS_REG_COUNT-1:0] free_mask;
    logic [`COUNT_BITS-1:0]     consumed;
    logic                       dispatch_valid;
    logic [`COUNT_BITS-1:0]     dispatch_count;
    logic [`XLEN-1:0]           disp_pc [`DISPATCH_WIDTH];
    op_class_e                  disp_op_class [`DISPATCH_WIDTH];
    opb_select_e                disp_opb_select [`DISPATCH_WIDTH];
    logic [`XLEN-1:0]           disp_imm [`DISPATCH_WIDTH];
    logic [`REG_IDX_BITS-1:0]   disp_rs1 [`DISPATCH_WIDTH];
    logic [`REG_IDX_BITS-1:0]   disp_rs2 [`DISPATCH_WIDTH];
    logic [`REG_IDX_BITS-1:0]   disp_rd [`DISPATCH_WIDTH];
    logic [`DISPATCH_WIDTH-1:0] disp_uses_rd;
    logic [`PHYS_TAG_BITS-1:0]  disp_phys_rd [`DISPATCH_WIDTH];
    logic [`DISPATCH_WIDTH-1:0] disp_illegal;
    logic [`DISPATCH_WIDTH-1:0] disp_halt;

    // Stimulus table with one row per bundle
    logic [31:0]  tbl_word [NUM_ENTRIES][2];
    lane_expect_t tbl_lane [NUM_ENTRIES][2];
    logic [31:0]  tbl_pc [NUM_ENTRIES];
    logic [1:0]   tbl_count [NUM_ENTRIES];
    logic [63:0]  tbl_mask [NUM_ENTRIES];
    int           n_entries;

    // Reference model state and the packet it predicts
    logic [63:0]  model_free;
    integer       seed;
    lane_expect_t exp_dec [2];
    logic [31:0]  exp_word [2];
    logic [31:0]  exp_pc;
    logic [1:0]   exp_go;
    logic [5:0]   exp_tag [2];
    logic [1:0]   exp_consumed;

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    dispatch_front dut0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .bundle_valid   (bundle_valid),
        .bundle_pc      (bundle_pc),
        .bundle_insts   (bundle_insts),
        .bundle_count   (bundle_count),
        .consumed       (consumed),
        .free_mask      (free_mask),
        .dispatch_valid (dispatch_valid),
        .dispatch_count (dispatch_count),
        .disp_pc        (disp_pc),
        .disp_op_class  (disp_op_class),
        .disp_opb_select(disp_opb_select),
        .disp_imm       (disp_imm),
        .disp_rs1       (disp_rs1),
        .disp_rs2       (disp_rs2),
        .disp_rd        (disp_rd),
        .disp_uses_rd   (disp_uses_rd),
        .disp_phys_rd   (disp_phys_rd),
        .disp_illegal   (disp_illegal),
        .disp_halt      (disp_halt)
    );

    ////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            $display("mismatch %s: got %h expected %h", name, got, want);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first error");
        end
    endtask

    // Decode of each table word as worked out by hand from the ISA
    function automatic lane_expect_t expected_decode(input logic [31:0] word);
        case (word)
            ADD_X3:  return '{OP_ALU, OPB_IS_RS2, 32'h0, 1'b1, 1'b0, 1'b0};
            MUL_X5:  return '{OP_MULT, OPB_IS_RS2, 32'h0, 1'b1, 1'b0, 1'b0};
            ADDI_X4: return '{OP_ALU, OPB_IS_I_IMM, 32'hffff_fffb, 1'b1, 1'b0, 1'b0};
            LW_X8:   return '{OP_LOAD, OPB_IS_I_IMM, 32'hffff_fffc, 1'b1, 1'b0, 1'b0};
            SW_X5:   return '{OP_STORE, OPB_IS_S_IMM, 32'hffff_fff4, 1'b0, 1'b0, 1'b0};
            BEQ_M16: return '{OP_BRANCH, OPB_IS_B_IMM, 32'hffff_fff0, 1'b0, 1'b0, 1'b0};
            LUI_X9:  return '{OP_ALU, OPB_IS_U_IMM, 32'h1234_5000, 1'b1, 1'b0, 1'b0};
            JAL_X1:  return '{OP_JUMP, OPB_IS_J_IMM, 32'hffff_fff8, 1'b1, 1'b0, 1'b0};
            RET:     return '{OP_JUMP, OPB_IS_I_IMM, 32'h0, 1'b0, 1'b0, 1'b0};
            BAD_OPC: return '{OP_ALU, OPB_IS_RS2, 32'h0, 1'b0, 1'b1, 1'b0};
            WFI:     return '{OP_SYSTEM, OPB_IS_RS2, 32'h0, 1'b0, 1'b0, 1'b1};
            default: return '{OP_ALU, OPB_IS_RS2, 32'h0, 1'b0, 1'b0, 1'b0};
        endcase
    endfunction

    // n-th lowest free tag in the model or -1 when the list is that short
    function automatic int nth_free(input int n);
        int seen;
        seen = 0;
        for (int t = 0; t < 64; t++) begin
            if (model_free[t]) begin
                if (seen == n) begin
                    return t;
                end
                seen++;
            end
        end
        return -1;
    endfunction

    // In-order lane walk followed by the take and release update of the bitmap
    task automatic predict_dispatch(input logic [1:0] count, input logic [63:0] mask);
        logic        chain;
        int          used;
        int          tag;
        logic [63:0] taken;
        chain        = 1'b1;
        used         = 0;
        taken        = '0;
        exp_consumed = 2'd0;
        for (int i = 0; i < 2; i++) begin
            exp_go[i]  = 1'b0;
            exp_tag[i] = '0;
            tag        = exp_dec[i].uses_rd ? nth_free(used) : 0;
            if (chain && (i < int'(count)) && (tag >= 0)) begin
                exp_go[i]    = 1'b1;
                exp_consumed = exp_consumed + 2'd1;
                if (exp_dec[i].uses_rd) begin
                    exp_tag[i] = 6'(tag);
                    taken[tag] = 1'b1;
                    used++;
                end
                chain = !exp_dec[i].halt;
            end else begin
                chain = 1'b0;
            end
        end
        // Released tags win over a take on the same edge
        model_free = (model_free & ~taken) | mask;
    endtask

    task automatic check_lanes();
        lane_expect_t want;
        logic [31:0]  want_word;
        logic [31:0]  want_pc;
        for (int i = 0; i < 2; i++) begin
            // Lanes left behind read as zero
            want      = exp_go[i] ? exp_dec[i] : '0;
            want_word = exp_go[i] ? exp_word[i] : '0;
            want_pc   = exp_go[i] ? exp_pc + 32'(4 * i) : '0;
            compare_value($sformatf("disp_pc[%0d]", i), disp_pc[i], want_pc);
            compare_value($sformatf("disp_op_class[%0d]", i), 32'(disp_op_class[i]),
                          32'(want.op_class));
            compare_value($sformatf("disp_opb_select[%0d]", i), 32'(disp_opb_select[i]),
                          32'(want.opb_select));
            compare_value($sformatf("disp_imm[%0d]", i), disp_imm[i], want.imm);
            compare_value($sformatf("disp_rs1[%0d]", i), 32'(disp_rs1[i]), 32'(want_word[19:15]));
            compare_value($sformatf("disp_rs2[%0d]", i), 32'(disp_rs2[i]), 32'(want_word[24:20]));
            compare_value($sformatf("disp_rd[%0d]", i), 32'(disp_rd[i]), 32'(want_word[11:7]));
            compare_value($sformatf("disp_uses_rd[%0d]", i), 32'(disp_uses_rd[i]),
                          32'(want.uses_rd));
            compare_value($sformatf("disp_phys_rd[%0d]", i), 32'(disp_phys_rd[i]),
                          32'(exp_tag[i]));
            compare_value($sformatf("disp_illegal[%0d]", i), 32'(disp_illegal[i]),
                          32'(want.illegal));
            compare_value($sformatf("disp_halt[%0d]", i), 32'(disp_halt[i]), 32'(want.halt));
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // One strobe cycle followed by one idle cycle in which the packet is checked
    task automatic apply_bundle(input logic [31:0] w0, input lane_expect_t e0,
                                input logic [31:0] w1, input lane_expect_t e1,
                                input logic [31:0] pc, input logic [1:0] count,
                                input logic [63:0] mask);
        @(posedge clock);
        bundle_valid    <= 1'b1;
        bundle_pc       <= pc;
        bundle_insts[0] <= w0;
        bundle_insts[1] <= w1;
        bundle_count    <= count;
        free_mask       <= mask;
        exp_word[0] = w0;
        exp_word[1] = w1;
        exp_dec[0]  = e0;
        exp_dec[1]  = e1;
        exp_pc      = pc;
        predict_dispatch(count, mask);
        @(negedge clock);
        compare_value("consumed", 32'(consumed), 32'(exp_consumed));
        // Previous cycle was idle so no packet yet
        compare_value("dispatch_valid", 32'(dispatch_valid), 32'h0);
        @(posedge clock);
        bundle_valid <= 1'b0;
        free_mask    <= '0;
        @(negedge clock);
        // Nothing is consumed without a strobe
        compare_value("consumed", 32'(consumed), 32'h0);
        compare_value("dispatch_valid", 32'(dispatch_valid), 32'h1);
        compare_value("dispatch_count", 32'(dispatch_count), 32'(exp_consumed));
        check_lanes();
    endtask

    // Two addi words with a nonzero rd so both lanes want a tag
    task automatic apply_random_bundle();
        logic [31:0]  w [2];
        lane_expect_t e [2];
        logic [31:0]  r;
        logic [4:0]   rd;
        for (int i = 0; i < 2; i++) begin
            r    = $random(seed);
            rd   = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            w[i] = {r[31:20], r[19:15], 3'b000, rd, 7'b0010011};
            e[i] = '{OP_ALU, OPB_IS_I_IMM, {{20{r[31]}}, r[31:20]}, 1'b1, 1'b0, 1'b0};
        end
        apply_bundle(w[0], e[0], w[1], e[1], 32'h0000_3000, 2'd2, 64'h0);
    endtask

    task automatic add_entry(input logic [31:0] w0, input logic [31:0] w1,
                             input logic [31:0] pc, input logic [1:0] count,
                             input logic [63:0] mask);
        tbl_word[n_entries][0] = w0;
        tbl_word[n_entries][1] = w1;
        tbl_lane[n_entries][0] = expected_decode(w0);
        tbl_lane[n_entries][1] = expected_decode(w1);
        tbl_pc[n_entries]      = pc;
        tbl_count[n_entries]   = count;
        tbl_mask[n_entries]    = mask;
        n_entries++;
    endtask

    task automatic fill_table();
        // Every format and class with tags from 32 upward
        add_entry(ADD_X3, MUL_X5, 32'h0000_1000, 2'd2, '0);
        add_entry(ADDI_X4, LW_X8, 32'h0000_1008, 2'd2, '0);
        add_entry(SW_X5, BEQ_M16, 32'h0000_1010, 2'd2, '0);
        add_entry(LUI_X9, JAL_X1, 32'h0000_1018, 2'd2, '0);
        // x0 target and unknown opcode take no tag
        add_entry(RET, BAD_OPC, 32'h0000_1020, 2'd2, '0);
        // Halt in lane 0 holds back lane 1
        add_entry(WFI, ADDI_X4, 32'h0000_1028, 2'd2, '0);
        add_entry(ADD_X3, MUL_X5, 32'h0000_1030, 2'd1, '0);
        add_entry(ADD_X3, ADD_X3, 32'h0000_1038, 2'd0, '0);
        // Only tag 63 is left here so lane 1 stalls
        add_entry(ADDI_X4, ADD_X3, 32'h0000_2000, 2'd2, '0);
        // Lane 0 stalls on the empty list and the store behind it waits
        add_entry(ADD_X3, SW_X5, 32'h0000_2008, 2'd2, (64'd1 << 40) | (64'd1 << 35));
        // Released tags 35 and 40 come back lowest first
        add_entry(MUL_X5, LW_X8, 32'h0000_2010, 2'd2, '0);
        add_entry(SW_X5, ADDI_X4, 32'h0000_2018, 2'd2, '0);
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        seed            = 32'hd2eaf1a0;
        n_entries       = 0;
        rst_n           <= 1'b0;
        bundle_valid    <= 1'b0;
        bundle_pc       <= '0;
        bundle_insts[0] <= '0;
        bundle_insts[1] <= '0;
        bundle_count    <= '0;
        free_mask       <= '0;
        // Low 32 tags hold the architectural state out of reset
        model_free      = {{32{1'b1}}, {32{1'b0}}};
        fill_table();
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        exp_go     = '0;
        exp_tag[0] = '0;
        exp_tag[1] = '0;
        compare_value("dispatch_valid", 32'(dispatch_valid), 32'h0);
        compare_value("dispatch_count", 32'(dispatch_count), 32'h0);
        check_lanes();
        for (int i = 0; i < n_entries; i++) begin
            // Drain the free list before the stall rows
            if (i == RANDOM_AT) begin
                repeat (NUM_RANDOM) apply_random_bundle();
            end
            apply_bundle(tbl_word[i][0], tbl_lane[i][0], tbl_word[i][1], tbl_lane[i][1],
                         tbl_pc[i], tbl_count[i], tbl_mask[i]);
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

endmodule

// ==== build.f ====
+incdir+.
dispatch_pkg.sv
inst_decoder.sv
free_list.sv
dispatch_packer.sv
dispatch_front.sv
tb_dispatch_front.sv

// ==== run.sh ====
#!/bin/sh
# Compile the dispatch front end and its testbench with Verilator, then run it.
# The exit status is the simulator's, so a failing run returns nonzero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_dispatch_front \
    -o sim_dispatch_front
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/sim_dispatch_front
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit $sim_status
fi

exit 0
